// ==== all.f ====
+incdir+tests
src/mdu_pkg.sv
src/m_decoder.sv
src/mul_unit.sv
src/div_unit.sv
src/mdu_sequencer.sv
src/mdu_top.sv
tests/mdu_tb.sv

// ==== src/div_unit.sv ====
module div_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 div_start_i,
  input  mdu_pkg::div_req_t    div_req_i,
  output logic                 div_busy_o,
  output logic                 div_done_o,
  output mdu_pkg::mdu_result_t div_result_o
);

  // Request decode
  logic              is_signed;
  logic              sign_a;
  logic              sign_b;
  logic [31:0]       mag_a;
  logic [31:0]       mag_b;

  // Iteration state
  logic [31:0]       dividend_q;
  logic [31:0]       dvs_q;
  logic [31:0]       rem_q;
  logic [31:0]       quo_q;
  logic [4:0]        cnt_q;
  logic              neg_quo_q;
  logic              neg_rem_q;
  logic              div_zero_q;
  logic              ovf_q;
  mdu_pkg::div_op_e  op_q;
  logic [4:0]        rd_q;

  // One restoring step
  logic [32:0]       shift_rem;
  logic [32:0]       trial;
  logic [31:0]       step_rem;
  logic [31:0]       step_quo;
  logic [31:0]       quo_fix;
  logic [31:0]       rem_fix;

  assign is_signed = (div_req_i.div_operator == mdu_pkg::DIV_DIV) ||
                     (div_req_i.div_operator == mdu_pkg::DIV_REM);
  assign sign_a    = is_signed & div_req_i.op_a[31];
  assign sign_b    = is_signed & div_req_i.op_b[31];
  assign mag_a     = sign_a ? -div_req_i.op_a : div_req_i.op_a;
  assign mag_b     = sign_b ? -div_req_i.op_b : div_req_i.op_b;

  // Shift in next dividend bit, try to subtract
  assign shift_rem = {rem_q, quo_q[31]};
  assign trial     = shift_rem - {1'b0, dvs_q};
  assign step_rem  = trial[32] ? shift_rem[31:0] : trial[31:0];
  assign step_quo  = {quo_q[30:0], ~trial[32]};

  // Sign correction for the final step
  assign quo_fix   = neg_quo_q ? -step_quo : step_quo;
  assign rem_fix   = neg_rem_q ? -step_rem : step_rem;

  ////////////////////////////////////////////////////////////////////////////
  // Control, busy spans the done cycle as well
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_busy_o <= 1'b0;
      div_done_o <= 1'b0;
      cnt_q      <= '0;
    end else if (div_start_i) begin
      div_busy_o <= 1'b1;
      cnt_q      <= '0;
    end else if (div_done_o) begin
      div_busy_o <= 1'b0;
      div_done_o <= 1'b0;
    end else if (div_busy_o) begin
      cnt_q      <= cnt_q + 5'd1;
      div_done_o <= (cnt_q == 5'd31);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (div_start_i) begin
      dividend_q <= div_req_i.op_a;
      dvs_q      <= mag_b;
      rem_q      <= '0;
      quo_q      <= mag_a;
      neg_quo_q  <= sign_a ^ sign_b;
      neg_rem_q  <= sign_a;
      div_zero_q <= (div_req_i.op_b == 32'd0);
      ovf_q      <= is_signed && (div_req_i.op_a == 32'h8000_0000) &&
                    (div_req_i.op_b == 32'hFFFF_FFFF);
      op_q       <= div_req_i.div_operator;
      rd_q       <= div_req_i.rd;
    end else if (div_busy_o && !div_done_o) begin
      rem_q <= step_rem;
      quo_q <= step_quo;
      // Last step, resolve special cases and pick the word
      if (cnt_q == 5'd31) begin
        div_result_o.rd      <= rd_q;
        div_result_o.illegal <= 1'b0;
        if (div_zero_q) begin
          div_result_o.value <= (op_q == mdu_pkg::DIV_DIV || op_q == mdu_pkg::DIV_DIVU) ?
                                32'hFFFF_FFFF : dividend_q;
        end else if (ovf_q) begin
          div_result_o.value <= (op_q == mdu_pkg::DIV_DIV) ? dividend_q : 32'd0;
        end else begin
          div_result_o.value <= (op_q == mdu_pkg::DIV_DIV || op_q == mdu_pkg::DIV_DIVU) ?
                                quo_fix : rem_fix;
        end
      end
    end
  end

  // Sequencer must hold off while an op is running
  assert property (@(posedge clk_i) disable iff (!rst_n_i) div_start_i |-> !div_busy_o);

endmodule

// ==== src/m_decoder.sv ====
module m_decoder (
  input  logic [31:0]       instr_rdata_i,
  output mdu_pkg::mdu_ctrl_t decoder_ctrl_o
);

  always_comb begin
    // Start from the illegal pattern with the flag cleared
    decoder_ctrl_o              = mdu_pkg::MDU_CTRL_ILLEGAL;
    decoder_ctrl_o.illegal_insn = 1'b0;

    unique case (instr_rdata_i[6:0])
      mdu_pkg::OPCODE_OP: begin
        // Every RV32M op writes rd
        decoder_ctrl_o.rf_we = 1'b1;

        // funct7 and funct3 select the operation
        unique case ({instr_rdata_i[31:25], instr_rdata_i[14:12]})
          {7'b000_0001, 3'b000}: begin // mul, low word
            decoder_ctrl_o.mul_en          = 1'b1;
            decoder_ctrl_o.mul_operator    = mdu_pkg::MUL_M32;
            decoder_ctrl_o.mul_signed_mode = 2'b00;
          end
          {7'b000_0001, 3'b001}: begin // mulh, signed x signed
            decoder_ctrl_o.mul_en          = 1'b1;
            decoder_ctrl_o.mul_operator    = mdu_pkg::MUL_H;
            decoder_ctrl_o.mul_signed_mode = 2'b11;
          end
          {7'b000_0001, 3'b010}: begin // mulhsu, signed x unsigned
            decoder_ctrl_o.mul_en          = 1'b1;
            decoder_ctrl_o.mul_operator    = mdu_pkg::MUL_H;
            decoder_ctrl_o.mul_signed_mode = 2'b10;
          end
          {7'b000_0001, 3'b011}: begin // mulhu
            decoder_ctrl_o.mul_en          = 1'b1;
            decoder_ctrl_o.mul_operator    = mdu_pkg::MUL_H;
            decoder_ctrl_o.mul_signed_mode = 2'b00;
          end
          {7'b000_0001, 3'b100}: begin // div
            decoder_ctrl_o.div_en       = 1'b1;
            decoder_ctrl_o.div_operator = mdu_pkg::DIV_DIV;
          end
          {7'b000_0001, 3'b101}: begin // divu
            decoder_ctrl_o.div_en       = 1'b1;
            decoder_ctrl_o.div_operator = mdu_pkg::DIV_DIVU;
          end
          {7'b000_0001, 3'b110}: begin // rem
            decoder_ctrl_o.div_en       = 1'b1;
            decoder_ctrl_o.div_operator = mdu_pkg::DIV_REM;
          end
          {7'b000_0001, 3'b111}: begin // remu
            decoder_ctrl_o.div_en       = 1'b1;
            decoder_ctrl_o.div_operator = mdu_pkg::DIV_REMU;
          end
          default: decoder_ctrl_o = mdu_pkg::MDU_CTRL_ILLEGAL;
        endcase
      end
      default: decoder_ctrl_o = mdu_pkg::MDU_CTRL_ILLEGAL;
    endcase
  end

endmodule

// ==== src/mdu_pkg.sv ====
package mdu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and operator encodings
  ////////////////////////////////////////////////////////////////////////////

  // Major opcode of register-register operations
  localparam logic [6:0] OPCODE_OP = 7'h33;

  // Multiplier result word select
  typedef enum logic {
    MUL_M32 = 1'b0,
    MUL_H   = 1'b1
  } mul_op_e;

  // Divider operation, quotient ops first
  typedef enum logic [1:0] {
    DIV_DIV  = 2'b00,
    DIV_DIVU = 2'b01,
    DIV_REM  = 2'b10,
    DIV_REMU = 2'b11
  } div_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder output
  ////////////////////////////////////////////////////////////////////////////

  // Signed mode: bit 1 for operand a, bit 0 for operand b
  typedef struct packed {
    logic       illegal_insn;
    logic       rf_we;
    logic       mul_en;
    mul_op_e    mul_operator;
    logic [1:0] mul_signed_mode;
    logic       div_en;
    div_op_e    div_operator;
  } mdu_ctrl_t;

  // Decode result for anything outside RV32M
  localparam mdu_ctrl_t MDU_CTRL_ILLEGAL = '{
    illegal_insn:    1'b1,
    rf_we:           1'b0,
    mul_en:          1'b0,
    mul_operator:    MUL_M32,
    mul_signed_mode: 2'b00,
    div_en:          1'b0,
    div_operator:    DIV_DIV
  };

  ////////////////////////////////////////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////////////////////////////////////////

  // Instruction plus operands from the issue stage
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  rd;
  } mdu_issue_t;

  // Tagged result towards writeback
  typedef struct packed {
    logic [31:0] value;
    logic [4:0]  rd;
    logic        illegal;
  } mdu_result_t;

  typedef struct packed {
    logic [31:0] op_a;
    logic [31:0] op_b;
    mul_op_e     mul_operator;
    logic [1:0]  mul_signed_mode;
    logic [4:0]  rd;
  } mul_req_t;

  typedef struct packed {
    logic [31:0] op_a;
    logic [31:0] op_b;
    div_op_e     div_operator;
    logic [4:0]  rd;
  } div_req_t;

endpackage

// ==== src/mdu_sequencer.sv ====
module mdu_sequencer #(
  parameter int IQ_DEPTH    = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Issue side
  input  logic                 issue_valid_i,
  input  mdu_pkg::mdu_issue_t  issue_i,
  output logic                 issue_credit_o,
  // Result side
  input  logic                 res_credit_i,
  output logic                 result_valid_o,
  output mdu_pkg::mdu_result_t result_o,
  // Decoder
  output logic [31:0]          head_instr_o,
  input  mdu_pkg::mdu_ctrl_t   head_ctrl_i,
  // Multiplier
  output logic                 mul_valid_o,
  output mdu_pkg::mul_req_t    mul_req_o,
  input  logic                 mul_done_i,
  input  mdu_pkg::mdu_result_t mul_result_i,
  // Divider
  output logic                 div_start_o,
  output mdu_pkg::div_req_t    div_req_o,
  input  logic                 div_busy_i,
  input  logic                 div_done_i,
  input  mdu_pkg::mdu_result_t div_result_i
);

  localparam int PTR_W  = $clog2(IQ_DEPTH);
  localparam int CRED_W = $clog2(RES_CREDITS + 1);

  // Instruction queue, pointers carry a wrap bit
  mdu_pkg::mdu_issue_t iq_mem [IQ_DEPTH];
  logic [PTR_W:0]      wr_ptr_q;
  logic [PTR_W:0]      rd_ptr_q;
  logic                iq_empty;
  logic                iq_full;
  mdu_pkg::mdu_issue_t head;

  logic [CRED_W-1:0]   credit_q;
  // Multiplies in stage 1 and stage 2
  logic [1:0]          mul_pend_q;
  logic                head_is_mul;
  logic                head_is_div;
  logic                dispatch;
  logic                ill_dispatch;

  assign iq_empty = (wr_ptr_q == rd_ptr_q);
  assign iq_full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                    (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign head     = iq_mem[rd_ptr_q[PTR_W-1:0]];

  assign head_instr_o = head.instr;
  assign head_is_mul  = head_ctrl_i.rf_we & head_ctrl_i.mul_en;
  assign head_is_div  = head_ctrl_i.rf_we & head_ctrl_i.div_en;

  ////////////////////////////////////////////////////////////////////////////
  // Dispatch
  ////////////////////////////////////////////////////////////////////////////

  // Divides and illegal results wait for the multiplier to drain
  assign dispatch     = !iq_empty && (credit_q != '0) && !div_busy_i &&
                        (head_is_mul || (mul_pend_q == 2'b00));
  assign ill_dispatch = dispatch && !head_is_mul && !head_is_div;
  assign mul_valid_o  = dispatch && head_is_mul;
  assign div_start_o  = dispatch && head_is_div;

  always_comb begin
    mul_req_o.op_a            = head.op_a;
    mul_req_o.op_b            = head.op_b;
    mul_req_o.mul_operator    = head_ctrl_i.mul_operator;
    mul_req_o.mul_signed_mode = head_ctrl_i.mul_signed_mode;
    mul_req_o.rd              = head.rd;
    div_req_o.op_a            = head.op_a;
    div_req_o.op_b            = head.op_b;
    div_req_o.div_operator    = head_ctrl_i.div_operator;
    div_req_o.rd              = head.rd;
  end

  // Queue storage
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      iq_mem[wr_ptr_q[PTR_W-1:0]] <= issue_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers, credits and result merge
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      credit_q       <= CRED_W'(RES_CREDITS);
      mul_pend_q     <= 2'b00;
      issue_credit_o <= 1'b0;
      result_valid_o <= 1'b0;
    end else begin
      if (issue_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (dispatch) rd_ptr_q <= rd_ptr_q + 1'b1;
      // One credit back to the core per popped entry
      issue_credit_o <= dispatch;
      if (dispatch && !res_credit_i) begin
        credit_q <= credit_q - 1'b1;
      end else if (!dispatch && res_credit_i) begin
        credit_q <= credit_q + 1'b1;
      end
      mul_pend_q     <= {mul_pend_q[0], mul_valid_o};
      result_valid_o <= mul_done_i | div_done_i | ill_dispatch;
    end
  end

  // Sources never collide, gating above keeps them apart
  always_ff @(posedge clk_i) begin
    if (mul_done_i) begin
      result_o <= mul_result_i;
    end else if (div_done_i) begin
      result_o <= div_result_i;
    end else if (ill_dispatch) begin
      result_o.value   <= 32'd0;
      result_o.rd      <= head.rd;
      result_o.illegal <= head_ctrl_i.illegal_insn;
    end
  end

  // Core honours its issue credits
  assert property (@(posedge clk_i) disable iff (!rst_n_i) issue_valid_i |-> !iq_full);
  // Writeback never returns more than it was granted
  assert property (@(posedge clk_i) disable iff (!rst_n_i) credit_q <= RES_CREDITS);

endmodule

// ==== src/mdu_top.sv ====
module mdu_top #(
  parameter int IQ_DEPTH    = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 issue_valid_i,
  input  mdu_pkg::mdu_issue_t  issue_i,
  output logic                 issue_credit_o,
  input  logic                 res_credit_i,
  output logic                 result_valid_o,
  output mdu_pkg::mdu_result_t result_o
);

  // Decoder loop
  logic [31:0]          head_instr;
  mdu_pkg::mdu_ctrl_t   head_ctrl;

  // Multiplier channel
  logic                 mul_valid;
  mdu_pkg::mul_req_t    mul_req;
  logic                 mul_done;
  mdu_pkg::mdu_result_t mul_result;

  // Divider channel
  logic                 div_start;
  mdu_pkg::div_req_t    div_req;
  logic                 div_busy;
  logic                 div_done;
  mdu_pkg::mdu_result_t div_result;

  mdu_sequencer #(
    .IQ_DEPTH    (IQ_DEPTH),
    .RES_CREDITS (RES_CREDITS)
  ) u_sequencer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_valid_i  (issue_valid_i),
    .issue_i        (issue_i),
    .issue_credit_o (issue_credit_o),
    .res_credit_i   (res_credit_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .head_instr_o   (head_instr),
    .head_ctrl_i    (head_ctrl),
    .mul_valid_o    (mul_valid),
    .mul_req_o      (mul_req),
    .mul_done_i     (mul_done),
    .mul_result_i   (mul_result),
    .div_start_o    (div_start),
    .div_req_o      (div_req),
    .div_busy_i     (div_busy),
    .div_done_i     (div_done),
    .div_result_i   (div_result)
  );

  m_decoder u_decoder (
    .instr_rdata_i  (head_instr),
    .decoder_ctrl_o (head_ctrl)
  );

  mul_unit u_mul (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mul_valid_i  (mul_valid),
    .mul_req_i    (mul_req),
    .mul_done_o   (mul_done),
    .mul_result_o (mul_result)
  );

  div_unit u_div (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .div_start_i  (div_start),
    .div_req_i    (div_req),
    .div_busy_o   (div_busy),
    .div_done_o   (div_done),
    .div_result_o (div_result)
  );

endmodule

// ==== src/mul_unit.sv ====
module mul_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 mul_valid_i,
  input  mdu_pkg::mul_req_t    mul_req_i,
  output logic                 mul_done_o,
  output mdu_pkg::mdu_result_t mul_result_o
);

  // Operands widened by one bit so all sign modes share one signed multiply
  logic signed [32:0] op_a_ext;
  logic signed [32:0] op_b_ext;

  // Stage 1 state
  logic signed [65:0] prod_q;
  mdu_pkg::mul_op_e   op_q;
  logic [4:0]         rd_q;
  logic               valid_q;

  assign op_a_ext = {mul_req_i.mul_signed_mode[1] & mul_req_i.op_a[31], mul_req_i.op_a};
  assign op_b_ext = {mul_req_i.mul_signed_mode[0] & mul_req_i.op_b[31], mul_req_i.op_b};

  ////////////////////////////////////////////////////////////////////////////
  // Valid pipe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q    <= 1'b0;
      mul_done_o <= 1'b0;
    end else begin
      valid_q    <= mul_valid_i;
      mul_done_o <= valid_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data pipe
  ////////////////////////////////////////////////////////////////////////////

  // Stage 1, full product
  always_ff @(posedge clk_i) begin
    prod_q <= op_a_ext * op_b_ext;
    op_q   <= mul_req_i.mul_operator;
    rd_q   <= mul_req_i.rd;
  end

  // Stage 2, word select
  always_ff @(posedge clk_i) begin
    mul_result_o.value   <= (op_q == mdu_pkg::MUL_H) ? prod_q[63:32] : prod_q[31:0];
    mul_result_o.rd      <= rd_q;
    mul_result_o.illegal <= 1'b0;
  end

endmodule

// ==== tests/mdu_ref.svh ====
`ifndef MDU_REF_SVH
`define MDU_REF_SVH

// Product word for mul, mulh, mulhsu, mulhu, selected by funct3
function automatic logic [31:0] mul_word(input logic [2:0] funct3, input logic [31:0] a,
                                         input logic [31:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [63:0] ub;
  logic [63:0]        prod;
  sa = {{32{a[31]}}, a};
  sb = {{32{b[31]}}, b};
  ub = {32'd0, b};
  case (funct3[1:0])
    2'b00:   prod = sa * sb;
    2'b01:   prod = sa * sb;
    2'b10:   prod = sa * ub;
    default: prod = {32'd0, a} * {32'd0, b};
  endcase
  // Only mul keeps the low word
  return (funct3[1:0] == 2'b00) ? prod[31:0] : prod[63:32];
endfunction

// Quotient or remainder for div, divu, rem, remu with RV32M corner rules
function automatic logic [31:0] div_word(input logic [2:0] funct3, input logic [31:0] a,
                                         input logic [31:0] b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  logic signed [31:0] res;
  logic               ovf;
  sa  = a;
  sb  = b;
  ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  // Divide by zero, all ones or the dividend
  if (b == 32'd0) return funct3[1] ? a : 32'hffff_ffff;
  case (funct3[1:0])
    2'b00: begin
      if (ovf) return a;
      res = sa / sb;
      return res;
    end
    2'b01: return a / b;
    2'b10: begin
      if (ovf) return 32'd0;
      res = sa % sb;
      return res;
    end
    default: return a % b;
  endcase
endfunction

// Full tagged result expected for one issued instruction
function automatic mdu_pkg::mdu_result_t expected_result(input logic [31:0] instr,
                                                         input logic [31:0] a,
                                                         input logic [31:0] b,
                                                         input logic [4:0]  rd);
  mdu_pkg::mdu_result_t r;
  r.rd      = rd;
  r.value   = 32'd0;
  r.illegal = (instr[6:0] != mdu_pkg::OPCODE_OP) || (instr[31:25] != 7'b000_0001);
  if (!r.illegal) begin
    // funct3 bit 2 splits multiplies from divides
    r.value = instr[14] ? div_word(instr[14:12], a, b) : mul_word(instr[14:12], a, b);
  end
  return r;
endfunction

`endif

// ==== tests/mdu_tb.sv ====
module mdu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  `include "mdu_ref.svh"

  localparam int IQ_DEPTH    = 4;
  localparam int RES_CREDITS = 2;
  localparam int RST_CYCLES  = 16;
  localparam int WAIT_LIMIT  = 2000;
  localparam logic [31:0] CORNERS [5] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
                                          32'h7fff_ffff, 32'h1};

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 issue_valid_i;
  mdu_pkg::mdu_issue_t  issue_i;
  logic                 issue_credit_o;
  logic                 res_credit_i;
  logic                 result_valid_o;
  mdu_pkg::mdu_result_t result_o;

  // Scoreboard, head mirrored for the assertions
  mdu_pkg::mdu_result_t exp_q [$];
  mdu_pkg::mdu_result_t exp_head;
  int                   exp_pending = 0;
  // Results taken by writeback, not yet credited back
  int                   wb_held     = 0;
  int                   wb_gap      = 0;
  int                   iq_credits  = 0;
  int                   issued      = 0;
  int                   credit_pulses = 0;
  int                   results_seen  = 0;
  int                   errors      = 0;
  int                   cyc         = 0;

  mdu_top uut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_valid_i  (issue_valid_i),
    .issue_i        (issue_i),
    .issue_credit_o (issue_credit_o),
    .res_credit_i   (res_credit_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Bookkeeping at each rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (rst_n_i && result_valid_o) begin
      if (exp_q.size() > 0) void'(exp_q.pop_front());
      results_seen++;
    end
    exp_pending <= exp_q.size();
    if (exp_q.size() > 0) exp_head <= exp_q[0];
    wb_held <= wb_held + int'(rst_n_i && result_valid_o) - int'(rst_n_i && res_credit_i);
    // Issue credits come back one per dispatch
    if (rst_n_i && issue_credit_o) begin
      iq_credits++;
      credit_pulses++;
    end
  end

  // Writeback drains results after random gaps
  always begin
    @(posedge clk_i);
    #1;
    res_credit_i = 1'b0;
    if (rst_n_i && wb_held > 0) begin
      if (wb_gap == 0) begin
        res_credit_i = 1'b1;
        wb_gap       = $urandom_range(5, 0);
      end else begin
        wb_gap--;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Quiet outputs through reset and just after release
  assert property (@(posedge clk_i) (cyc >= 1 && cyc <= RST_CYCLES + 1) |->
                   !result_valid_o && !issue_credit_o)
    else begin
      errors++;
      $display("outputs active during or right after reset");
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) result_valid_o |-> exp_pending > 0)
    else begin
      errors++;
      $display("result delivered with no instruction outstanding");
    end

  // Value is don't care for illegal encodings
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   result_valid_o && exp_pending > 0 |->
                   exp_head.illegal || result_o.value == exp_head.value)
    else begin
      errors++;
      $display("mismatch result_o.value: got %h expected %h",
               $sampled(result_o.value), $sampled(exp_head.value));
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   result_valid_o && exp_pending > 0 |-> result_o.rd == exp_head.rd)
    else begin
      errors++;
      $display("mismatch result_o.rd: got %h expected %h",
               $sampled(result_o.rd), $sampled(exp_head.rd));
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   result_valid_o && exp_pending > 0 |-> result_o.illegal == exp_head.illegal)
    else begin
      errors++;
      $display("mismatch result_o.illegal: got %h expected %h",
               $sampled(result_o.illegal), $sampled(exp_head.illegal));
    end

  // A new result needs a free writeback slot
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   result_valid_o |-> wb_held < RES_CREDITS)
    else begin
      errors++;
      $display("result delivered without a result credit");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Driver helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
    $display("errors %0d, results checked %0d, issued %0d, issue credits %0d",
             errors, results_seen, issued, credit_pulses);
    $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  function automatic logic [31:0] pick_operand();
    if ($urandom_range(3, 0) == 0) return CORNERS[$urandom_range(4, 0)];
    return $urandom();
  endfunction

  // One R-type issue, spends a queue credit
  task automatic issue_insn(input logic [6:0] funct7, input logic [2:0] funct3,
                            input logic [6:0] opcode, input logic [31:0] a,
                            input logic [31:0] b);
    logic [4:0] rd;
    int         waited;
    rd     = 5'($urandom());
    waited = 0;
    while (iq_credits == 0) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) fail_timeout("an issue credit");
    end
    issue_i.instr = {funct7, 5'($urandom()), 5'($urandom()), funct3, rd, opcode};
    issue_i.op_a  = a;
    issue_i.op_b  = b;
    issue_i.rd    = rd;
    issue_valid_i = 1'b1;
    iq_credits--;
    issued++;
    exp_q.push_back(expected_result(issue_i.instr, a, b, rd));
    exp_head    <= exp_q[0];
    exp_pending <= exp_q.size();
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int waited;
    void'($urandom(32'h3a74e0d3));
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    res_credit_i  = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i    = 1'b1;
    iq_credits = IQ_DEPTH;

    // Corner operands through every mul and div variant
    for (int f = 0; f < 8; f++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          issue_insn(7'b000_0001, 3'(f), mdu_pkg::OPCODE_OP, CORNERS[i], CORNERS[j]);
        end
      end
    end

    // Wrong opcode, wrong funct7, base ALU funct3 patterns
    issue_insn(7'b000_0001, 3'b000, 7'h13, $urandom(), $urandom());
    issue_insn(7'b000_0001, 3'b100, 7'h3b, $urandom(), $urandom());
    for (int f = 0; f < 8; f++) begin
      issue_insn(7'b000_0000, 3'(f), mdu_pkg::OPCODE_OP, $urandom(), $urandom());
      issue_insn(7'b010_0000, 3'(f), mdu_pkg::OPCODE_OP, $urandom(), $urandom());
    end
    issue_insn(7'b100_0001, 3'b001, mdu_pkg::OPCODE_OP, $urandom(), $urandom());

    // Multiply bursts right behind a divide
    repeat (8) begin
      issue_insn(7'b000_0001, 3'($urandom_range(7, 4)), mdu_pkg::OPCODE_OP,
                 pick_operand(), pick_operand());
      repeat (3) begin
        issue_insn(7'b000_0001, 3'($urandom_range(3, 0)), mdu_pkg::OPCODE_OP,
                   pick_operand(), pick_operand());
      end
    end

    // Random mix, roughly one in eight illegal
    repeat (200) begin
      if ($urandom_range(7, 0) == 0) begin
        issue_insn(7'b010_0000, 3'($urandom()), mdu_pkg::OPCODE_OP, $urandom(), $urandom());
      end else begin
        issue_insn(7'b000_0001, 3'($urandom()), mdu_pkg::OPCODE_OP,
                   pick_operand(), pick_operand());
      end
      idle_cycles($urandom_range(2, 0));
    end

    // Drain results and writeback credits
    waited = 0;
    while (exp_q.size() != 0 || wb_held != 0) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) fail_timeout("the run to drain");
    end

    assert (credit_pulses == issued)
      else begin
        errors++;
        $display("mismatch issue_credit_o pulses: got %h expected %h", credit_pulses, issued);
      end
    $display("errors %0d, results checked %0d, issued %0d, issue credits %0d",
             errors, results_seen, issued, credit_pulses);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
